//--- source/boot_ctrl_cfg.svh
/*
 * configuration macros for the boot controller
 * fuse word count, register word addresses and the default firmware-update wait
 */
`ifndef BOOT_CTRL_CFG_SVH
`define BOOT_CTRL_CFG_SVH

// number of 32-bit fuse words held in the register block
`define BOOT_CTRL_FUSE_WORDS     8

// word addresses on the strobe bus
`define BOOT_CTRL_ADDR_FUSE_BASE 0
`define BOOT_CTRL_ADDR_FUSE_DONE 8
`define BOOT_CTRL_ADDR_DBG       9
`define BOOT_CTRL_ADDR_FW_UPD    10
`define BOOT_CTRL_ADDR_STATUS    11

// wait count used by the firmware-update reset when nothing else is written
`define BOOT_CTRL_WAIT_DEFAULT   8'd16

`endif

//--- source/boot_ctrl_pkg.sv
/*
 * shared types of the boot controller
 * boot state encoding and the register address type
 */
package boot_ctrl_pkg;

    // boot sequencer states
    // the encoding is also what the status register returns in bits 2:0
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // word address on the register strobe bus
    typedef logic [5:0] reg_addr_t;

endpackage

//--- source/boot_fsm.sv
/*
 * boot sequencer state machine
 * warm reset window tracking, two stage reset outputs and the firmware-update wait timer
 */
`timescale 1ns/1ps

module boot_fsm (
    input  logic                           clk,
    input  logic                           cptra_pwrgood,
    input  logic                           cptra_rst_b,
    input  logic                           scan_mode,
    input  logic                           fw_update_rst,
    input  logic [7:0]                     fw_update_rst_wait_cycles,
    input  logic                           BootFSM_BrkPoint,
    input  logic                           BootFSM_Continue,
    input  logic                           fuse_done,
    input  logic                           fuse_wr_done_observed,
    output logic                           ready_for_fuses,
    output boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps,
    output logic                           cptra_noncore_rst_b,
    output logic                           cptra_uc_rst_b,
    output logic                           iccm_unlock,
    output logic                           fw_upd_rst_executed,
    output logic                           rdc_clk_dis,
    output logic                           fw_update_rst_window
);
    import boot_ctrl_pkg::*;

    boot_fsm_state_e boot_fsm_ns;

    // warm reset window chain
    logic rst_window;
    logic rst_window_f;
    logic rst_window_2f;
    logic rst_window_3f;

    // reset requests from the state decode and their two register stages
    logic fsm_noncore_rst_b;
    logic fsm_uc_rst_b;
    logic synch_noncore_rst_b;
    logic synch_uc_rst_b;
    logic noncore_rst_b_q;
    logic uc_rst_b_q;

    logic       fsm_iccm_unlock;
    logic [7:0] wait_count;
    logic       wait_load;
    logic       wait_decr;

    logic arc_to_idle;
    logic arc_idle_fuse;
    logic arc_fuse_exit;
    logic arc_done_fw_rst;
    logic arc_fw_rst_wait;
    logic arc_wait_done;

    // the state is forced back to IDLE one stage into the warm reset window
    assign arc_to_idle     = rst_window_f;
    // leave IDLE only once the window has drained through the second stage
    assign arc_idle_fuse   = ~rst_window_2f;
    // fuse_done survives warm reset so the SoC must also be seen writing it again
    assign arc_fuse_exit   = fuse_done & fuse_wr_done_observed;
    assign arc_done_fw_rst = fw_update_rst;
    // move on once the core reset request has reached the first stage
    assign arc_fw_rst_wait = ~synch_uc_rst_b;
    // a set breakpoint holds WAIT until continue is written
    assign arc_wait_done   = (wait_count == 8'd0) & ~(BootFSM_BrkPoint & ~BootFSM_Continue);

    // the window marks the span where only the core is being reset
    assign fw_update_rst_window = (boot_fsm_ps == BOOT_FW_RST) | (boot_fsm_ps == BOOT_WAIT);
    // clocks may be stopped from the reset assertion until the chain has emptied
    assign rdc_clk_dis = rst_window | rst_window_f | rst_window_2f | rst_window_3f;

    always_comb begin
        boot_fsm_ns         = boot_fsm_ps;
        ready_for_fuses     = 1'b0;
        fw_upd_rst_executed = 1'b0;
        fsm_noncore_rst_b   = 1'b0;
        fsm_uc_rst_b        = 1'b0;
        fsm_iccm_unlock     = 1'b0;
        wait_load           = 1'b0;
        wait_decr           = 1'b0;

        case (boot_fsm_ps)
            BOOT_IDLE: begin
                // both resets stay asserted while the SoC holds warm reset
                if (arc_idle_fuse) begin
                    boot_fsm_ns = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                ready_for_fuses   = 1'b1;
                fsm_noncore_rst_b = 1'b1;
                if (arc_fuse_exit) begin
                    boot_fsm_ns = BootFSM_BrkPoint ? BOOT_WAIT : BOOT_DONE;
                end
            end
            BOOT_FW_RST: begin
                // core goes back into reset and the timer keeps reloading here
                fsm_noncore_rst_b = 1'b1;
                wait_load         = 1'b1;
                if (arc_fw_rst_wait) begin
                    boot_fsm_ns = BOOT_WAIT;
                end
            end
            BOOT_WAIT: begin
                fsm_noncore_rst_b = 1'b1;
                wait_decr         = 1'b1;
                if (arc_wait_done) begin
                    boot_fsm_ns = BOOT_DONE;
                    // ICCM opens only as the reset flow finishes
                    fsm_iccm_unlock = 1'b1;
                end
            end
            BOOT_DONE: begin
                fsm_noncore_rst_b = 1'b1;
                fsm_uc_rst_b      = 1'b1;
                if (arc_done_fw_rst) begin
                    boot_fsm_ns         = BOOT_FW_RST;
                    fw_upd_rst_executed = 1'b1;
                end
            end
            default: begin
                // unused codes recover through IDLE
                boot_fsm_ns = BOOT_IDLE;
            end
        endcase
    end

    // state, reset stages and window chain live on the cold reset
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            boot_fsm_ps         <= BOOT_IDLE;
            synch_noncore_rst_b <= 1'b0;
            synch_uc_rst_b      <= 1'b0;
            noncore_rst_b_q     <= 1'b0;
            uc_rst_b_q          <= 1'b0;
            rst_window_f        <= 1'b1;
            rst_window_2f       <= 1'b1;
            rst_window_3f       <= 1'b1;
        end else begin
            boot_fsm_ps         <= arc_to_idle ? BOOT_IDLE : boot_fsm_ns;
            synch_noncore_rst_b <= fsm_noncore_rst_b;
            synch_uc_rst_b      <= fsm_uc_rst_b;
            noncore_rst_b_q     <= synch_noncore_rst_b;
            // the core leaves reset only when the non-core request is also released
            uc_rst_b_q          <= synch_noncore_rst_b & synch_uc_rst_b;
            rst_window_f        <= rst_window;
            rst_window_2f       <= rst_window_f;
            rst_window_3f       <= rst_window_2f;
        end
    end

    // head of the window chain and the timer are cleared by warm reset
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rst_window  <= 1'b1;
            wait_count  <= 8'd0;
            iccm_unlock <= 1'b0;
        end else begin
            rst_window  <= 1'b0;
            iccm_unlock <= fsm_iccm_unlock;
            if (wait_decr && (wait_count != 8'd0)) begin
                wait_count <= wait_count - 8'd1;
            end else if (wait_load) begin
                wait_count <= fw_update_rst_wait_cycles;
            end
        end
    end

    // scan mode keeps both resets released
    assign cptra_noncore_rst_b = noncore_rst_b_q | scan_mode;
    assign cptra_uc_rst_b      = uc_rst_b_q | scan_mode;

endmodule

//--- source/boot_ctrl_regs.sv
/*
 * register block of the boot controller
 * fuse words with write lock, fuse-done flags, debug bits, firmware-update request and status
 */
`timescale 1ns/1ps

`include "boot_ctrl_cfg.svh"

module boot_ctrl_regs (
    input  logic                           clk,
    input  logic                           cptra_pwrgood,
    input  logic                           cptra_rst_b,
    input  logic                           req_wr,
    input  logic                           req_rd,
    input  boot_ctrl_pkg::reg_addr_t       req_addr,
    input  logic [31:0]                    req_wdata,
    input  logic                           ready_for_fuses,
    input  boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps,
    input  logic                           fw_upd_rst_executed,
    input  logic                           iccm_unlock,
    output logic [31:0]                    rd_data,
    output logic                           fuse_done,
    output logic                           fuse_wr_done_observed,
    output logic                           fw_update_rst,
    output logic [7:0]                     fw_update_rst_wait_cycles,
    output logic                           BootFSM_BrkPoint,
    output logic                           BootFSM_Continue
);
    import boot_ctrl_pkg::*;

    localparam int FUSE_IDX_W = $clog2(`BOOT_CTRL_FUSE_WORDS);

    logic [31:0]           fuse_q [`BOOT_CTRL_FUSE_WORDS];
    reg_addr_t             fuse_off;
    logic [FUSE_IDX_W-1:0] fuse_idx;
    logic                  hit_fuse;
    logic                  hit_fuse_done;
    logic                  hit_dbg;
    logic                  hit_fw_upd;
    logic                  hit_status;
    logic                  fuse_wr_en;
    logic                  fw_upd_seen;
    logic                  iccm_unlocked;
    logic [31:0]           rd_mux;

    // an address below the fuse base wraps high and misses the fuse range
    assign fuse_off      = req_addr - reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_BASE);
    assign fuse_idx      = fuse_off[FUSE_IDX_W-1:0];
    assign hit_fuse      = fuse_off < reg_addr_t'(`BOOT_CTRL_FUSE_WORDS);
    assign hit_fuse_done = req_addr == reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_DONE);
    assign hit_dbg       = req_addr == reg_addr_t'(`BOOT_CTRL_ADDR_DBG);
    assign hit_fw_upd    = req_addr == reg_addr_t'(`BOOT_CTRL_ADDR_FW_UPD);
    assign hit_status    = req_addr == reg_addr_t'(`BOOT_CTRL_ADDR_STATUS);

    // fuses take writes only in the fuse window and before fuse-done
    assign fuse_wr_en = req_wr & hit_fuse & ready_for_fuses & ~fuse_done;

    // fuse words and fuse_done keep their value through warm reset
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            for (int i = 0; i < `BOOT_CTRL_FUSE_WORDS; i++) begin
                fuse_q[i] <= 32'd0;
            end
            fuse_done <= 1'b0;
        end else begin
            if (fuse_wr_en) begin
                fuse_q[fuse_idx] <= req_wdata;
            end
            // set only, so the lock holds until power is cycled
            if (req_wr && hit_fuse_done && req_wdata[0]) begin
                fuse_done <= 1'b1;
            end
        end
    end

    // everything below restarts with each warm reset
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_wr_done_observed     <= 1'b0;
            BootFSM_BrkPoint          <= 1'b0;
            BootFSM_Continue          <= 1'b0;
            fw_update_rst             <= 1'b0;
            fw_update_rst_wait_cycles <= `BOOT_CTRL_WAIT_DEFAULT;
            fw_upd_seen               <= 1'b0;
            iccm_unlocked             <= 1'b0;
        end else begin
            // the SoC has to write fuse-done again after every warm reset
            if (req_wr && hit_fuse_done && req_wdata[0]) begin
                fuse_wr_done_observed <= 1'b1;
            end
            if (req_wr && hit_dbg) begin
                BootFSM_BrkPoint <= req_wdata[0];
                BootFSM_Continue <= req_wdata[1];
            end
            // request bit is write-one and lasts exactly one cycle
            fw_update_rst <= req_wr & hit_fw_upd & req_wdata[0];
            if (req_wr && hit_fw_upd) begin
                fw_update_rst_wait_cycles <= req_wdata[15:8];
            end
            // status keeps a record of the one-cycle events from the sequencer
            if (fw_upd_rst_executed) begin
                fw_upd_seen <= 1'b1;
            end
            if (iccm_unlock) begin
                iccm_unlocked <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_mux = 32'd0;
        if (hit_fuse) begin
            rd_mux = fuse_q[fuse_idx];
        end else if (hit_fuse_done) begin
            rd_mux[0] = fuse_done;
        end else if (hit_dbg) begin
            rd_mux[1:0] = {BootFSM_Continue, BootFSM_BrkPoint};
        end else if (hit_fw_upd) begin
            // the request bit always reads as zero
            rd_mux[15:8] = fw_update_rst_wait_cycles;
        end else if (hit_status) begin
            rd_mux[2:0] = boot_fsm_ps;
            rd_mux[3]   = fw_upd_seen;
            rd_mux[4]   = iccm_unlocked;
            rd_mux[5]   = ready_for_fuses;
        end
    end

    // read data appears in the cycle after the read strobe
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rd_data <= 32'd0;
        end else if (req_rd) begin
            rd_data <= rd_mux;
        end
    end

endmodule

//--- source/boot_ctrl_top.sv
/*
 * top level of the boot controller
 * register block and boot sequencer joined to the SoC ports
 */
`timescale 1ns/1ps

module boot_ctrl_top (
    input  logic                           clk,
    input  logic                           cptra_pwrgood,
    input  logic                           cptra_rst_b,
    input  logic                           scan_mode,
    input  logic                           req_wr,
    input  logic                           req_rd,
    input  boot_ctrl_pkg::reg_addr_t       req_addr,
    input  logic [31:0]                    req_wdata,
    output logic [31:0]                    rd_data,
    output logic                           cptra_noncore_rst_b,
    output logic                           cptra_uc_rst_b,
    output logic                           iccm_unlock,
    output logic                           rdc_clk_dis,
    output logic                           fw_update_rst_window,
    output boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps
);

    // register block to sequencer
    logic       fuse_done;
    logic       fuse_wr_done_observed;
    logic       fw_update_rst;
    logic [7:0] fw_update_rst_wait_cycles;
    logic       BootFSM_BrkPoint;
    logic       BootFSM_Continue;

    // sequencer back to the status register
    logic ready_for_fuses;
    logic fw_upd_rst_executed;

    boot_ctrl_regs u_regs (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .req_wr                    (req_wr),
        .req_rd                    (req_rd),
        .req_addr                  (req_addr),
        .req_wdata                 (req_wdata),
        .ready_for_fuses           (ready_for_fuses),
        .boot_fsm_ps               (boot_fsm_ps),
        .fw_upd_rst_executed       (fw_upd_rst_executed),
        .iccm_unlock               (iccm_unlock),
        .rd_data                   (rd_data),
        .fuse_done                 (fuse_done),
        .fuse_wr_done_observed     (fuse_wr_done_observed),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .BootFSM_BrkPoint          (BootFSM_BrkPoint),
        .BootFSM_Continue          (BootFSM_Continue)
    );

    boot_fsm u_boot_fsm (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .scan_mode                 (scan_mode),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .BootFSM_BrkPoint          (BootFSM_BrkPoint),
        .BootFSM_Continue          (BootFSM_Continue),
        .fuse_done                 (fuse_done),
        .fuse_wr_done_observed     (fuse_wr_done_observed),
        .ready_for_fuses           (ready_for_fuses),
        .boot_fsm_ps               (boot_fsm_ps),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .iccm_unlock               (iccm_unlock),
        .fw_upd_rst_executed       (fw_upd_rst_executed),
        .rdc_clk_dis               (rdc_clk_dis),
        .fw_update_rst_window      (fw_update_rst_window)
    );

endmodule

//--- tb/tb_clk_gen.sv
/*
 * free running testbench clock with a 40 ns period
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // first rising edge lands at 20 ns
    initial clk = 1'b0;

    always #20 clk = ~clk;

endmodule

//--- tb/boot_ctrl_props.sv
/*
 * concurrent checks on the boot sequencer reset outputs, state flow and ICCM unlock
 * bound into the boot controller top level
 */
`timescale 1ns/1ps

module boot_ctrl_props (
    input logic                           clk,
    input logic                           cptra_pwrgood,
    input logic                           cptra_rst_b,
    input logic                           scan_mode,
    input logic                           cptra_noncore_rst_b,
    input logic                           cptra_uc_rst_b,
    input logic                           iccm_unlock,
    input logic                           rdc_clk_dis,
    input logic                           fw_update_rst_window,
    input boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps,
    input logic                           ready_for_fuses,
    input logic                           fuse_done,
    input logic                           fuse_wr_done_observed,
    input logic [7:0]                     fw_update_rst_wait_cycles,
    input logic                           BootFSM_BrkPoint,
    input logic                           BootFSM_Continue
);
    import boot_ctrl_pkg::*;

    // number of properties that have failed so far
    int unsigned fail_count = 0;

    logic [8:0] uc_low_cycles;
    logic       in_fw_flow;
    logic       iccm_seen;

    // length of the current core reset, and whether it came from a firmware update
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            uc_low_cycles <= 9'd0;
            in_fw_flow    <= 1'b0;
            iccm_seen     <= 1'b0;
        end else begin
            if (cptra_uc_rst_b) begin
                uc_low_cycles <= 9'd0;
            end else if (uc_low_cycles != 9'h1ff) begin
                uc_low_cycles <= uc_low_cycles + 9'd1;
            end
            if (boot_fsm_ps == BOOT_FW_RST) begin
                in_fw_flow <= 1'b1;
            end else if (cptra_uc_rst_b) begin
                in_fw_flow <= 1'b0;
            end
            // the unlock pulse has to show up between FW_RST and the core release
            if (iccm_unlock) begin
                iccm_seen <= 1'b1;
            end else if (boot_fsm_ps == BOOT_FW_RST) begin
                iccm_seen <= 1'b0;
            end
        end
    end

    // cold reset leaves everything in reset with the clock disable raised
    a_reset_values: assert property (@(posedge clk) !cptra_pwrgood && !scan_mode |->
        !cptra_noncore_rst_b && !cptra_uc_rst_b && !iccm_unlock && !ready_for_fuses && rdc_clk_dis)
        else begin fail_count++; $error("reset outputs wrong while cold reset is held"); end

    a_scan_override: assert property (@(posedge clk) scan_mode |->
        cptra_noncore_rst_b && cptra_uc_rst_b)
        else begin fail_count++; $error("scan mode did not hold both resets released"); end

    a_noncore_rise: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $rose(cptra_noncore_rst_b) && !scan_mode |-> boot_fsm_ps != BOOT_IDLE)
        else begin fail_count++; $error("non-core reset released before the fuse window"); end

    a_uc_needs_noncore: assert property (@(posedge clk)
        cptra_uc_rst_b && !scan_mode |-> cptra_noncore_rst_b)
        else begin fail_count++; $error("core out of reset while non-core is still in reset"); end

    // breakpoint without continue parks the sequencer in WAIT
    a_brk_hold: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        boot_fsm_ps == BOOT_WAIT && BootFSM_BrkPoint && !BootFSM_Continue |=>
        boot_fsm_ps == BOOT_WAIT)
        else begin fail_count++; $error("sequencer left WAIT while the breakpoint was held"); end

    a_wait_core_reset: assert property (@(posedge clk)
        boot_fsm_ps == BOOT_WAIT && !scan_mode |-> !cptra_uc_rst_b)
        else begin fail_count++; $error("core reset released while the sequencer was in WAIT"); end

    a_fuse_exit: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        boot_fsm_ps == BOOT_FUSE && fuse_done && fuse_wr_done_observed && !BootFSM_BrkPoint |=>
        boot_fsm_ps == BOOT_DONE)
        else begin fail_count++; $error("fuse window did not close straight into DONE"); end

    // the core only goes into reset during a warm reset or the firmware-update window
    a_uc_fall: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $fell(cptra_uc_rst_b) && !scan_mode |->
        rdc_clk_dis || (fw_update_rst_window && cptra_noncore_rst_b))
        else begin fail_count++; $error("core reset asserted outside a reset window"); end

    // the non-core reset only drops inside a warm reset window
    a_noncore_fall: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $fell(cptra_noncore_rst_b) && !scan_mode |-> rdc_clk_dis)
        else begin fail_count++; $error("non-core reset asserted outside warm reset"); end

    a_uc_low_min: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $rose(cptra_uc_rst_b) && in_fw_flow && !scan_mode |->
        uc_low_cycles >= fw_update_rst_wait_cycles && iccm_seen)
        else begin fail_count++; $error("firmware update reset too short or ICCM not unlocked"); end

    a_iccm_pulse: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        iccm_unlock |-> !cptra_uc_rst_b ##1 !iccm_unlock)
        else begin fail_count++; $error("ICCM unlock not a single pulse ahead of core release"); end

    a_warm_idle: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $fell(cptra_rst_b) |-> ##2 boot_fsm_ps == BOOT_IDLE)
        else begin fail_count++; $error("sequencer did not return to IDLE after warm reset"); end

    // clock disable lasts four edges past the warm reset release
    a_release_window: assert property (@(posedge clk) disable iff (!cptra_pwrgood)
        $rose(cptra_rst_b) |-> rdc_clk_dis [*4] ##1 !rdc_clk_dis)
        else begin fail_count++; $error("clock disable window has the wrong length"); end

endmodule

bind boot_ctrl_top boot_ctrl_props u_props (
    .clk                       (clk),
    .cptra_pwrgood             (cptra_pwrgood),
    .cptra_rst_b               (cptra_rst_b),
    .scan_mode                 (scan_mode),
    .cptra_noncore_rst_b       (cptra_noncore_rst_b),
    .cptra_uc_rst_b            (cptra_uc_rst_b),
    .iccm_unlock               (iccm_unlock),
    .rdc_clk_dis               (rdc_clk_dis),
    .fw_update_rst_window      (fw_update_rst_window),
    .boot_fsm_ps               (boot_fsm_ps),
    .ready_for_fuses           (ready_for_fuses),
    .fuse_done                 (fuse_done),
    .fuse_wr_done_observed     (fuse_wr_done_observed),
    .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
    .BootFSM_BrkPoint          (BootFSM_BrkPoint),
    .BootFSM_Continue          (BootFSM_Continue)
);

//--- tb/boot_ctrl_tb.sv
/*
 * testbench top for the boot controller
 * reset and scan sequence, strobe bus tasks, LFSR fuse data and the boot scenarios
 */
`timescale 1ns/1ps

`include "boot_ctrl_cfg.svh"

module boot_ctrl_tb;
    import boot_ctrl_pkg::*;

    // wait used by the firmware-update reset scenario
    localparam logic [7:0] FW_WAIT = 8'd12;

    logic            clk;
    logic            cptra_pwrgood;
    logic            cptra_rst_b;
    logic            scan_mode;
    logic            req_wr;
    logic            req_rd;
    reg_addr_t       req_addr;
    logic [31:0]     req_wdata;
    logic [31:0]     rd_data;
    logic            cptra_noncore_rst_b;
    logic            cptra_uc_rst_b;
    logic            iccm_unlock;
    logic            rdc_clk_dis;
    logic            fw_update_rst_window;
    boot_fsm_state_e boot_fsm_ps;

    logic [31:0] lfsr;
    logic [31:0] fuse_words [`BOOT_CTRL_FUSE_WORDS];

    tb_clk_gen u_clk_gen (
        .clk (clk)
    );

    boot_ctrl_top DUT (
        .clk                  (clk),
        .cptra_pwrgood        (cptra_pwrgood),
        .cptra_rst_b          (cptra_rst_b),
        .scan_mode            (scan_mode),
        .req_wr               (req_wr),
        .req_rd               (req_rd),
        .req_addr             (req_addr),
        .req_wdata            (req_wdata),
        .rd_data              (rd_data),
        .cptra_noncore_rst_b  (cptra_noncore_rst_b),
        .cptra_uc_rst_b       (cptra_uc_rst_b),
        .iccm_unlock          (iccm_unlock),
        .rdc_clk_dis          (rdc_clk_dis),
        .fw_update_rst_window (fw_update_rst_window),
        .boot_fsm_ps          (boot_fsm_ps)
    );

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit of the word
    task automatic take_random_word(output logic [31:0] w);
        w = 32'd0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic bus_write(input reg_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        req_wr    = 1'b1;
        req_addr  = addr;
        req_wdata = data;
        @(posedge clk);
        #2;
        req_wr = 1'b0;
    endtask

    // read data is registered on the edge after the strobe
    task automatic read_compare(input reg_addr_t addr, input logic [31:0] expected,
                                input logic [31:0] mask, input string name);
        @(posedge clk);
        #2;
        req_rd   = 1'b1;
        req_addr = addr;
        @(posedge clk);
        #2;
        req_rd = 1'b0;
        if ((rd_data & mask) !== (expected & mask)) begin
            $display("FAILED at %0t ns: %s expected 0x%08h actual 0x%08h",
                     $time, name, expected & mask, rd_data & mask);
            $display("TEST FAILED");
            $fatal(1, "register readback mismatch");
        end
    endtask

    task automatic wait_for_state(input boot_fsm_state_e target, input string what);
        int cycles;
        cycles = 0;
        while (boot_fsm_ps !== target) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles >= 500) begin
                $display("TEST FAILED");
                $fatal(1, "sequencer never reached the %s within 500 cycles", what);
            end
        end
    endtask

    task automatic wait_for_uc(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (cptra_uc_rst_b !== level) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles >= 500) begin
                $display("TEST FAILED");
                $fatal(1, "core reset did not change within 500 cycles during %s", what);
            end
        end
    endtask

    // any failed property in the bound checker ends the run at once
    always @(DUT.u_props.fail_count) begin
        if (DUT.u_props.fail_count != 0) begin
            $display("TEST FAILED");
            $fatal(1, "a boot sequencer property failed");
        end
    end

    initial begin
        logic [31:0] exp_status;
        lfsr          = 32'd94625;
        cptra_pwrgood = 1'b0;
        cptra_rst_b   = 1'b0;
        scan_mode     = 1'b1;
        req_wr        = 1'b0;
        req_rd        = 1'b0;
        req_addr      = reg_addr_t'(0);
        req_wdata     = 32'd0;

        // scan mode holds the resets released during the first half of reset
        repeat (4) @(posedge clk);
        #2;
        scan_mode = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        cptra_pwrgood = 1'b1;
        cptra_rst_b   = 1'b1;

        // cold boot fills the fuses with LFSR words and reads them back
        wait_for_state(BOOT_FUSE, "fuse window after cold boot");
        for (int i = 0; i < `BOOT_CTRL_FUSE_WORDS; i++) begin
            take_random_word(fuse_words[i]);
            bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_BASE + i), fuse_words[i]);
        end
        for (int i = 0; i < `BOOT_CTRL_FUSE_WORDS; i++) begin
            read_compare(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_BASE + i), fuse_words[i],
                         32'hffff_ffff, "rd_data fuse word");
        end

        // breakpoint set before fuse-done sends the sequencer to WAIT
        bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_DBG), 32'h1);
        bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_DONE), 32'h1);
        bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_BASE), ~fuse_words[0]);
        read_compare(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_BASE), fuse_words[0],
                     32'hffff_ffff, "rd_data locked fuse word 0");
        wait_for_state(BOOT_WAIT, "breakpoint wait");
        repeat (20) @(posedge clk);
        #2;
        bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_DBG), 32'h3);
        wait_for_uc(1'b1, "release after continue");

        // firmware-update reset with a programmed wait
        bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_FW_UPD), {16'd0, FW_WAIT, 8'h01});
        wait_for_uc(1'b0, "firmware-update reset entry");
        wait_for_uc(1'b1, "firmware-update reset exit");
        // state DONE with the firmware reset executed, ICCM unlocked and the fuse window closed
        exp_status = {26'd0, 1'b0, 1'b1, 1'b1, BOOT_DONE};
        read_compare(reg_addr_t'(`BOOT_CTRL_ADDR_STATUS), exp_status, 32'h0000_003f,
                     "rd_data status");
        // the wait count holds the value written with the request
        read_compare(reg_addr_t'(`BOOT_CTRL_ADDR_FW_UPD), {16'd0, FW_WAIT, 8'h00},
                     32'h0000_ff00, "rd_data fw_upd wait cycles");

        // warm reset keeps the fuses locked and needs a fresh fuse-done write
        @(posedge clk);
        #2;
        cptra_rst_b = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        cptra_rst_b = 1'b1;
        wait_for_state(BOOT_FUSE, "fuse window after warm reset");
        bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_BASE + 1), ~fuse_words[1]);
        bus_write(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_DONE), 32'h1);
        wait_for_uc(1'b1, "release after warm reset");
        read_compare(reg_addr_t'(`BOOT_CTRL_ADDR_FUSE_BASE + 1), fuse_words[1],
                     32'hffff_ffff, "rd_data fuse word 1 after warm reset");

        repeat (8) @(posedge clk);
        if (DUT.u_props.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "property failures counted at the end of the run");
        end
    end

endmodule

//--- files.f
+incdir+source
source/boot_ctrl_pkg.sv
source/boot_fsm.sv
source/boot_ctrl_regs.sv
source/boot_ctrl_top.sv
tb/tb_clk_gen.sv
tb/boot_ctrl_props.sv
tb/boot_ctrl_tb.sv
